/* project.f */
logic/pinmux_pkg.sv
logic/reg_bus_slave.sv
logic/pinmux_cfg_regs.sv
logic/gpio_in_sync.sv
logic/gpio_intr_ctrl.sv
logic/pinmux_top.sv
sim/pinmux_properties.sv
sim/pinmux_tb.sv

/* Bender.yml */
package:
  name: pinmux

sources:
  - files:
      - logic/pinmux_pkg.sv
      - logic/reg_bus_slave.sv
      - logic/pinmux_cfg_regs.sv
      - logic/gpio_in_sync.sv
      - logic/gpio_intr_ctrl.sv
      - logic/pinmux_top.sv
  - target: simulation
    files:
      - sim/pinmux_properties.sv
      - sim/pinmux_tb.sv

/* sim/pinmux_tb.sv */
// Pin multiplexer register block testbench

`timescale 1ns/100ps

module pinmux_tb;

   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 3;
   localparam int ACK_LIMIT  = 4;    // Cycles allowed before an ack
   localparam int STEP_SLOTS = 10;   // Watchdog budget per table entry

   typedef enum logic [2:0] {
      K_READ,
      K_WRITE,
      K_PINS,    // Drive gpio_in_data and follow the sync stages
      K_EVENT,   // One cycle gpio_int_event pulse
      K_CHECK    // Compare static outputs
   } step_kind_e;

   typedef struct packed {
      step_kind_e                  kind;
      pinmux_pkg::reg_idx_e        idx;
      logic [pinmux_pkg::BE_W-1:0] be;
      pinmux_pkg::reg_data_t       data;       // Write data, pins or event bits
      pinmux_pkg::reg_data_t       exp;        // Read data or fuse id on K_CHECK
      logic                        exp_intr;
   } step_t;

   logic                          mclk;
   logic                          h_reset_n;
   logic                          reg_cs;
   logic                          reg_wr;
   logic [pinmux_pkg::ADDR_W-1:0] reg_addr;
   pinmux_pkg::reg_data_t         reg_wdata;
   logic [pinmux_pkg::BE_W-1:0]   reg_be;
   pinmux_pkg::reg_data_t         reg_rdata;
   logic                          reg_ack;
   pinmux_pkg::gpio_vec_t         gpio_in_data;
   pinmux_pkg::gpio_vec_t         gpio_int_event;
   pinmux_pkg::reg_data_t         fuse_mhartid;
   pinmux_pkg::gpio_cfg_t         gpio_cfg;
   pinmux_pkg::gpio_vec_t         cfg_gpio_data_in;
   pinmux_pkg::gpio_vec_t         gpio_prev_indata;
   logic                          gpio_intr;

   step_t                 steps[$];
   pinmux_pkg::gpio_cfg_t cfg_shadow;    // Expected config from read entries
   logic                  table_ready;
   integer                seed;

   pinmux_top uut (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .reg_cs           (reg_cs),
      .reg_wr           (reg_wr),
      .reg_addr         (reg_addr),
      .reg_wdata        (reg_wdata),
      .reg_be           (reg_be),
      .reg_rdata        (reg_rdata),
      .reg_ack          (reg_ack),
      .gpio_in_data     (gpio_in_data),
      .gpio_int_event   (gpio_int_event),
      .fuse_mhartid     (fuse_mhartid),
      .gpio_cfg         (gpio_cfg),
      .cfg_gpio_data_in (cfg_gpio_data_in),
      .gpio_prev_indata (gpio_prev_indata),
      .gpio_intr        (gpio_intr)
   );

   initial
   begin
      mclk = 1'b0;
      forever #(CLK_PERIOD / 2) mclk = ~mclk;
   end

   // ---------------------------------------------------------------------
   // Failure reporting and compares
   // ---------------------------------------------------------------------
   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_word(input pinmux_pkg::reg_data_t got, input pinmux_pkg::reg_data_t exp,
                             input string what);
      if (got !== exp)
      begin
         stop_on_error($sformatf("ERR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_cfg(input pinmux_pkg::gpio_cfg_t got, input pinmux_pkg::gpio_cfg_t exp);
      if (got !== exp)
      begin
         stop_on_error($sformatf("ERR at %0t ns: gpio_cfg is %h, expected %h", $time, got, exp));
      end
   endtask

   task automatic check_vec(input pinmux_pkg::gpio_vec_t got, input pinmux_pkg::gpio_vec_t exp,
                            input string what);
      if (got !== exp)
      begin
         stop_on_error($sformatf("ERR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         stop_on_error($sformatf("ERR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   // ---------------------------------------------------------------------
   // Step drivers enter and leave just after a falling edge
   // ---------------------------------------------------------------------
   task automatic bus_access(input step_t s);
      int waited;
      reg_cs    = 1'b1;
      reg_wr    = (s.kind == K_WRITE);
      reg_addr  = {1'b0, s.idx, 2'b00};   // Word index into addr[6:2]
      reg_be    = s.be;
      reg_wdata = s.data;
      @(negedge mclk);
      waited = 1;
      while (reg_ack !== 1'b1 && waited < ACK_LIMIT)
      begin
         @(negedge mclk);
         waited++;
      end
      if (reg_ack !== 1'b1)
      begin
         stop_on_error($sformatf("No acknowledge within %0d cycles for an access to index %0d",
                                 ACK_LIMIT, s.idx));
      end
      check_word(reg_rdata, s.exp, $sformatf("read data of index %0d", s.idx));
      check_bit(gpio_intr, s.exp_intr, "gpio_intr");
      @(negedge mclk);   // Chip select held one more cycle
      check_bit(reg_ack, 1'b0, "reg_ack with chip select held");
      reg_cs = 1'b0;   // Release for one idle cycle
      reg_wr = 1'b0;
      @(negedge mclk);
      check_bit(reg_ack, 1'b0, "reg_ack after release");
   endtask

   task automatic drive_pins(input step_t s);
      pinmux_pkg::gpio_vec_t old_pins;
      old_pins     = gpio_in_data;
      gpio_in_data = s.data;
      @(negedge mclk);
      check_vec(gpio_prev_indata, old_pins, "gpio_prev_indata after one edge");
      @(negedge mclk);
      check_vec(gpio_prev_indata, s.data, "gpio_prev_indata");   // Two edges
      check_vec(cfg_gpio_data_in, old_pins, "cfg_gpio_data_in after two edges");
      @(negedge mclk);
      check_vec(cfg_gpio_data_in, s.data, "cfg_gpio_data_in");   // Three edges
      check_bit(gpio_intr, s.exp_intr, "gpio_intr");
   endtask

   task automatic pulse_event(input step_t s);
      gpio_int_event = s.data;
      @(negedge mclk);
      gpio_int_event = '0;
      check_bit(gpio_intr, s.exp_intr, "gpio_intr after event");
   endtask

   task automatic check_outputs(input step_t s);
      check_word(fuse_mhartid, s.exp, "fuse_mhartid");
      check_cfg(gpio_cfg, cfg_shadow);
      check_bit(gpio_intr, s.exp_intr, "gpio_intr");
   endtask

   // Config read-back also sets what gpio_cfg must show
   task automatic update_shadow(input step_t s);
      case (s.idx)
         pinmux_pkg::IDX_GPIO_OUT  : cfg_shadow.out_data       = s.exp;
         pinmux_pkg::IDX_GPIO_DIR  : cfg_shadow.dir_sel        = s.exp;
         pinmux_pkg::IDX_GPIO_TYPE : cfg_shadow.out_type       = s.exp;
         pinmux_pkg::IDX_POS_SEL   : cfg_shadow.posedge_sel    = s.exp;
         pinmux_pkg::IDX_NEG_SEL   : cfg_shadow.negedge_sel    = s.exp;
         pinmux_pkg::IDX_MFUNC_SEL : cfg_shadow.multi_func_sel = s.exp;
         default                   : ;
      endcase
   endtask

   // ---------------------------------------------------------------------
   // Stimulus table
   // ---------------------------------------------------------------------
   task automatic push_step(input step_kind_e kind, input pinmux_pkg::reg_idx_e idx,
                            input logic [pinmux_pkg::BE_W-1:0] be,
                            input pinmux_pkg::reg_data_t data,
                            input pinmux_pkg::reg_data_t exp, input logic exp_intr);
      step_t s;
      s = '{kind, idx, be, data, exp, exp_intr};
      steps.push_back(s);
   endtask

   task automatic build_table();
      pinmux_pkg::gpio_vec_t pat_a;
      pinmux_pkg::gpio_vec_t pat_b;
      pat_a = $random(seed);
      pat_b = $random(seed);
      // Reset values
      push_step(K_READ, pinmux_pkg::IDX_CHIP_ID, 4'hF, 32'h0, 32'h8949_0201, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_FUSE_ID, 4'hF, 32'h0, 32'hA55A_A55A, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_OUT, 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_DIR, 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_TYPE, 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_POS_SEL, 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_NEG_SEL, 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_MFUNC_SEL, 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_INT_MASK, 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_INT_STAT, 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_INT_SET, 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_IN, 4'hF, 32'h0, 32'h0, 1'b0);   // Pins low
      push_step(K_CHECK, pinmux_pkg::IDX_CHIP_ID, 4'h0, 32'h0, 32'hA55A_A55A, 1'b0);
      // Byte enabled writes return the old word
      push_step(K_WRITE, pinmux_pkg::IDX_FUSE_ID, 4'b0011, 32'h1234_5678, 32'hA55A_A55A, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_FUSE_ID, 4'hF, 32'h0, 32'hA55A_5678, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_GPIO_OUT, 4'b1111, 32'hDEAD_BEEF, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_OUT, 4'hF, 32'h0, 32'hDEAD_BEEF, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_GPIO_OUT, 4'b0100, 32'h1122_3344, 32'hDEAD_BEEF, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_OUT, 4'hF, 32'h0, 32'hDE22_BEEF, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_GPIO_DIR, 4'b1010, 32'hFFFF_FFFF, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_DIR, 4'hF, 32'h0, 32'hFF00_FF00, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_GPIO_TYPE, 4'b0001, 32'h5A5A_5A5A, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_TYPE, 4'hF, 32'h0, 32'h0000_005A, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_POS_SEL, 4'b1100, 32'h8765_4321, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_POS_SEL, 4'hF, 32'h0, 32'h8765_0000, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_NEG_SEL, 4'b0110, 32'h0F0F_0F0F, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_NEG_SEL, 4'hF, 32'h0, 32'h000F_0F00, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_MFUNC_SEL, 4'b1111, 32'h1357_9BDF, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_MFUNC_SEL, 4'hF, 32'h0, 32'h1357_9BDF, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_MFUNC_SEL, 4'b0000, 32'hFFFF_FFFF, 32'h1357_9BDF, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_MFUNC_SEL, 4'hF, 32'h0, 32'h1357_9BDF, 1'b0);
      push_step(K_CHECK, pinmux_pkg::IDX_CHIP_ID, 4'h0, 32'h0, 32'hA55A_5678, 1'b0);
      // Unmapped words
      push_step(K_WRITE, pinmux_pkg::reg_idx_e'(5'd7), 4'hF, 32'hFFFF_FFFF, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::reg_idx_e'(5'd7), 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_WRITE, pinmux_pkg::reg_idx_e'(5'd15), 4'hF, 32'hFFFF_FFFF, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::reg_idx_e'(5'd8), 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::reg_idx_e'(5'd31), 4'hF, 32'h0, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_OUT, 4'hF, 32'h0, 32'hDE22_BEEF, 1'b0);
      push_step(K_CHECK, pinmux_pkg::IDX_CHIP_ID, 4'h0, 32'h0, 32'hA55A_5678, 1'b0);
      // Input pins through the synchronizer
      push_step(K_PINS, pinmux_pkg::IDX_GPIO_IN, 4'h0, pat_a, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_IN, 4'hF, 32'h0, pat_a, 1'b0);
      push_step(K_PINS, pinmux_pkg::IDX_GPIO_IN, 4'h0, pat_b, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_GPIO_IN, 4'hF, 32'h0, pat_b, 1'b0);
      // Interrupt status with mask 0000FF00 first
      push_step(K_WRITE, pinmux_pkg::IDX_INT_MASK, 4'hF, 32'h0000_FF00, 32'h0, 1'b0);
      push_step(K_EVENT, pinmux_pkg::IDX_INT_STAT, 4'h0, 32'h0000_0011, 32'h0, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_INT_SET, 4'hF, 32'h0, 32'h0000_0011, 1'b0);
      push_step(K_EVENT, pinmux_pkg::IDX_INT_STAT, 4'h0, 32'h0000_0100, 32'h0, 1'b1);
      push_step(K_READ, pinmux_pkg::IDX_INT_STAT, 4'hF, 32'h0, 32'h0000_0111, 1'b1);
      push_step(K_WRITE, pinmux_pkg::IDX_INT_STAT, 4'hF, 32'h0000_0101, 32'h0000_0111, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_INT_STAT, 4'hF, 32'h0, 32'h0000_0010, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_INT_SET, 4'b0010, 32'h0000_8000, 32'h0000_0010, 1'b1);
      push_step(K_READ, pinmux_pkg::IDX_INT_SET, 4'hF, 32'h0, 32'h0000_8010, 1'b1);
      push_step(K_WRITE, pinmux_pkg::IDX_INT_SET, 4'b0001, 32'h0000_FF00, 32'h0000_8010, 1'b1);
      push_step(K_READ, pinmux_pkg::IDX_INT_STAT, 4'hF, 32'h0, 32'h0000_8010, 1'b1);
      push_step(K_WRITE, pinmux_pkg::IDX_INT_STAT, 4'b0010, 32'hFFFF_FFFF, 32'h0000_8010, 1'b0);
      push_step(K_READ, pinmux_pkg::IDX_INT_STAT, 4'hF, 32'h0, 32'h0000_0010, 1'b0);
      push_step(K_WRITE, pinmux_pkg::IDX_INT_MASK, 4'b0001, 32'h0000_0010, 32'h0000_FF00, 1'b1);
      push_step(K_READ, pinmux_pkg::IDX_INT_MASK, 4'hF, 32'h0, 32'h0000_FF10, 1'b1);
      push_step(K_CHECK, pinmux_pkg::IDX_CHIP_ID, 4'h0, 32'h0, 32'hA55A_5678, 1'b1);
   endtask

   // ---------------------------------------------------------------------
   // Watchdog and main sequence
   // ---------------------------------------------------------------------
   initial
   begin
      wait (table_ready === 1'b1);
      #((steps.size() * STEP_SLOTS + RST_CYCLES) * CLK_PERIOD);
      stop_on_error("Watchdog timeout, the stimulus table did not finish in time");
   end

   initial
   begin
      h_reset_n      = 1'b0;
      reg_cs         = 1'b0;
      reg_wr         = 1'b0;
      reg_addr       = '0;
      reg_wdata      = '0;
      reg_be         = '0;
      gpio_in_data   = '0;
      gpio_int_event = '0;
      cfg_shadow     = '0;   // Config resets to zero
      table_ready    = 1'b0;
      seed           = 32'hfac8;
      build_table();
      table_ready = 1'b1;
      repeat (RST_CYCLES) @(negedge mclk);
      h_reset_n = 1'b1;
      @(negedge mclk);
      foreach (steps[i])
      begin
         case (steps[i].kind)
            K_READ :
            begin
               bus_access(steps[i]);
               update_shadow(steps[i]);
            end
            K_WRITE : bus_access(steps[i]);
            K_PINS  : drive_pins(steps[i]);
            K_EVENT : pulse_event(steps[i]);
            default : check_outputs(steps[i]);
         endcase
      end
      $display("All checks passed");
      $finish;
   end

endmodule

/* sim/pinmux_properties.sv */
// Register bus acknowledge assertions

`timescale 1ns/100ps

module pinmux_properties (
   input logic mclk,
   input logic h_reset_n,
   input logic reg_cs,
   input logic reg_ack
);

   // ---------------------------------------------------------------------
   // Acknowledge shape
   // ---------------------------------------------------------------------
   // Single cycle pulse
   ack_one_cycle : assert property (
      @(posedge mclk) disable iff (!h_reset_n) reg_ack |=> !reg_ack
   ) else $error("reg_ack high on two cycles running");

   // Ack only answers a chip select seen at the previous edge
   ack_needs_cs : assert property (
      @(posedge mclk) disable iff (!h_reset_n) reg_ack |-> $past(reg_cs)
   ) else $error("reg_ack without chip select at the previous edge");

   ack_low_in_reset : assert property (
      @(posedge mclk) !h_reset_n |-> !reg_ack   // Async clear holds it low
   ) else $error("reg_ack high during reset");

endmodule

bind pinmux_top pinmux_properties u_props (
   .mclk      (mclk),
   .h_reset_n (h_reset_n),
   .reg_cs    (reg_cs),
   .reg_ack   (reg_ack)
);

/* logic/pinmux_top.sv */
// Pin multiplexer register block

`timescale 1ns/100ps

module pinmux_top (
   input  logic                           mclk,
   input  logic                           h_reset_n,

   // Register bus
   input  logic                           reg_cs,
   input  logic                           reg_wr,
   input  logic [pinmux_pkg::ADDR_W-1:0]  reg_addr,
   input  pinmux_pkg::reg_data_t          reg_wdata,
   input  logic [pinmux_pkg::BE_W-1:0]    reg_be,
   output pinmux_pkg::reg_data_t          reg_rdata,
   output logic                           reg_ack,

   // GPIO side
   input  pinmux_pkg::gpio_vec_t          gpio_in_data,      // Async pins
   input  pinmux_pkg::gpio_vec_t          gpio_int_event,    // From GPIO control
   output pinmux_pkg::reg_data_t          fuse_mhartid,
   output pinmux_pkg::gpio_cfg_t          gpio_cfg,
   output pinmux_pkg::gpio_vec_t          cfg_gpio_data_in,  // Captured pins
   output pinmux_pkg::gpio_vec_t          gpio_prev_indata,  // Second sync stage
   output logic                           gpio_intr
);

   pinmux_pkg::reg_wr_t   reg_wr_cmd;   // Decoded write strobe
   pinmux_pkg::gpio_vec_t int_mask;
   pinmux_pkg::gpio_vec_t int_status;

   reg_bus_slave u_bus (
      .mclk         (mclk),
      .h_reset_n    (h_reset_n),
      .reg_cs       (reg_cs),
      .reg_wr       (reg_wr),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_be       (reg_be),
      .fuse_mhartid (fuse_mhartid),
      .gpio_cfg     (gpio_cfg),
      .gpio_data_in (cfg_gpio_data_in),
      .int_status   (int_status),
      .int_mask     (int_mask),
      .reg_rdata    (reg_rdata),
      .reg_ack      (reg_ack),
      .reg_wr_cmd   (reg_wr_cmd)
   );

   pinmux_cfg_regs u_cfg (
      .mclk         (mclk),
      .h_reset_n    (h_reset_n),
      .reg_wr       (reg_wr_cmd),
      .fuse_mhartid (fuse_mhartid),
      .gpio_cfg     (gpio_cfg),
      .int_mask     (int_mask)
   );

   gpio_in_sync u_sync (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .gpio_in_data     (gpio_in_data),
      .gpio_prev_indata (gpio_prev_indata),
      .gpio_data_in     (cfg_gpio_data_in)
   );

   gpio_intr_ctrl u_intr (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .reg_wr         (reg_wr_cmd),
      .gpio_int_event (gpio_int_event),
      .int_mask       (int_mask),
      .int_status     (int_status),
      .gpio_intr      (gpio_intr)
   );

endmodule

/* logic/gpio_intr_ctrl.sv */
// GPIO interrupt status and mask

`timescale 1ns/100ps

module gpio_intr_ctrl (
   input  logic                  mclk,
   input  logic                  h_reset_n,
   input  pinmux_pkg::reg_wr_t   reg_wr,           // Write command from bus
   input  pinmux_pkg::gpio_vec_t gpio_int_event,   // Edge events, one cycle
   input  pinmux_pkg::gpio_vec_t int_mask,
   output pinmux_pkg::gpio_vec_t int_status,
   output logic                  gpio_intr          // To the core
);

   pinmux_pkg::gpio_vec_t be_mask;    // Byte enables spread to bits
   pinmux_pkg::gpio_vec_t clr_bits;
   pinmux_pkg::gpio_vec_t set_bits;
   logic                  stat_clr;   // W1C word hit
   logic                  stat_set;   // W1S word hit

   assign stat_clr = reg_wr.en && (reg_wr.idx == pinmux_pkg::IDX_INT_STAT);
   assign stat_set = reg_wr.en && (reg_wr.idx == pinmux_pkg::IDX_INT_SET);

   // ---------------------------------------------------------------------
   // Software set and clear masks
   // ---------------------------------------------------------------------
   always_comb
   begin
      for (int b = 0; b < pinmux_pkg::BE_W; b++)
      begin
         be_mask[b*8 +: 8] = {8{reg_wr.be[b]}};
      end
      clr_bits = stat_clr ? (reg_wr.wdata & be_mask) : '0;
      set_bits = stat_set ? (reg_wr.wdata & be_mask) : '0;
   end

   // Status updates every cycle, events ORed last so they beat a clear
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         int_status <= '0;
      end
      else
      begin
         int_status <= (int_status & ~clr_bits) | set_bits | gpio_int_event;
      end
   end

   assign gpio_intr = |(int_status & int_mask);   // Masked irq line

endmodule

/* logic/gpio_in_sync.sv */
// GPIO input synchronizer

`timescale 1ns/100ps

module gpio_in_sync (
   input  logic                  mclk,
   input  logic                  h_reset_n,
   input  pinmux_pkg::gpio_vec_t gpio_in_data,       // Async pad inputs
   output pinmux_pkg::gpio_vec_t gpio_prev_indata,   // Second stage
   output pinmux_pkg::gpio_vec_t gpio_data_in        // Capture stage
);

   pinmux_pkg::gpio_vec_t pin_s1;   // First flop, may go metastable
   pinmux_pkg::gpio_vec_t pin_s2;

   // Two-flop sync plus capture, edge detect compares s2 against capture
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         pin_s1       <= '0;
         pin_s2       <= '0;
         gpio_data_in <= '0;
      end
      else
      begin
         pin_s1       <= gpio_in_data;
         pin_s2       <= pin_s1;
         gpio_data_in <= pin_s2;   // One cycle behind s2
      end
   end

   assign gpio_prev_indata = pin_s2;

endmodule

/* logic/pinmux_cfg_regs.sv */
// GPIO configuration registers

`timescale 1ns/100ps

module pinmux_cfg_regs (
   input  logic                  mclk,
   input  logic                  h_reset_n,
   input  pinmux_pkg::reg_wr_t   reg_wr,         // Write command from bus

   output pinmux_pkg::reg_data_t fuse_mhartid,   // Core hart id
   output pinmux_pkg::gpio_cfg_t gpio_cfg,
   output pinmux_pkg::gpio_vec_t int_mask        // GPIO irq enables
);

   // Byte lane merge of new data into a stored word
   function automatic pinmux_pkg::reg_data_t be_merge(
      input pinmux_pkg::reg_data_t         cur,
      input pinmux_pkg::reg_data_t         wdata,
      input logic [pinmux_pkg::BE_W-1:0]   be
   );
      pinmux_pkg::reg_data_t res;
      res = cur;
      for (int b = 0; b < pinmux_pkg::BE_W; b++)
      begin
         if (be[b])
         begin
            res[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return res;
   endfunction

   // ---------------------------------------------------------------------
   // Register bank
   // ---------------------------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         fuse_mhartid <= pinmux_pkg::FUSE_ID_RST;
         gpio_cfg     <= '0;
         int_mask     <= '0;
      end
      else if (reg_wr.en)
      begin
         case (reg_wr.idx)
            pinmux_pkg::IDX_FUSE_ID   :
               fuse_mhartid <= be_merge(fuse_mhartid, reg_wr.wdata, reg_wr.be);
            pinmux_pkg::IDX_GPIO_OUT  :
               gpio_cfg.out_data <= be_merge(gpio_cfg.out_data, reg_wr.wdata, reg_wr.be);
            pinmux_pkg::IDX_GPIO_DIR  :
               gpio_cfg.dir_sel <= be_merge(gpio_cfg.dir_sel, reg_wr.wdata, reg_wr.be);
            pinmux_pkg::IDX_GPIO_TYPE :
               gpio_cfg.out_type <= be_merge(gpio_cfg.out_type, reg_wr.wdata, reg_wr.be);
            pinmux_pkg::IDX_INT_MASK  :
               int_mask <= be_merge(int_mask, reg_wr.wdata, reg_wr.be);
            pinmux_pkg::IDX_POS_SEL   :
               gpio_cfg.posedge_sel <= be_merge(gpio_cfg.posedge_sel, reg_wr.wdata,
                                                reg_wr.be);
            pinmux_pkg::IDX_NEG_SEL   :
               gpio_cfg.negedge_sel <= be_merge(gpio_cfg.negedge_sel, reg_wr.wdata,
                                                reg_wr.be);
            pinmux_pkg::IDX_MFUNC_SEL :
               gpio_cfg.multi_func_sel <= be_merge(gpio_cfg.multi_func_sel, reg_wr.wdata,
                                                   reg_wr.be);
            default : ;   // Status words handled in interrupt block
         endcase
      end
   end

endmodule

/* logic/reg_bus_slave.sv */
// Register bus decoder and read-back

`timescale 1ns/100ps

module reg_bus_slave (
   input  logic                           mclk,
   input  logic                           h_reset_n,

   // Register bus
   input  logic                           reg_cs,
   input  logic                           reg_wr,      // 1 write, 0 read
   input  logic [pinmux_pkg::ADDR_W-1:0]  reg_addr,
   input  pinmux_pkg::reg_data_t          reg_wdata,
   input  logic [pinmux_pkg::BE_W-1:0]    reg_be,

   // Read-back sources
   input  pinmux_pkg::reg_data_t          fuse_mhartid,
   input  pinmux_pkg::gpio_cfg_t          gpio_cfg,
   input  pinmux_pkg::gpio_vec_t          gpio_data_in,
   input  pinmux_pkg::gpio_vec_t          int_status,
   input  pinmux_pkg::gpio_vec_t          int_mask,

   output pinmux_pkg::reg_data_t          reg_rdata,
   output logic                           reg_ack,
   output pinmux_pkg::reg_wr_t            reg_wr_cmd   // To register banks
);

   pinmux_pkg::reg_idx_e  acc_idx;    // Word index of this access
   pinmux_pkg::reg_data_t rd_word;    // Mux output
   logic                  acc_busy;   // Access already acked, cs still held
   logic                  acc_req;    // Sample edge qualifier

   // ---------------------------------------------------------------------
   // Access qualification
   // ---------------------------------------------------------------------
   assign acc_idx = pinmux_pkg::reg_idx_e'(reg_addr[6:2]);   // Word aligned
   assign acc_req = reg_cs & ~acc_busy;   // Only first cycle of cs counts

   // One-shot write command, lands with the ack edge
   assign reg_wr_cmd.en    = acc_req & reg_wr;
   assign reg_wr_cmd.idx   = acc_idx;
   assign reg_wr_cmd.be    = reg_be;
   assign reg_wr_cmd.wdata = reg_wdata;

   // Ack and busy tracking
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         reg_ack  <= 1'b0;
         acc_busy <= 1'b0;
      end
      else
      begin
         reg_ack  <= acc_req;   // Single cycle pulse
         acc_busy <= reg_cs;    // Held until master drops cs
      end
   end

   // ---------------------------------------------------------------------
   // Read path
   // ---------------------------------------------------------------------
   always_comb
   begin
      rd_word = '0;   // Unmapped words read zero
      case (acc_idx)
         pinmux_pkg::IDX_CHIP_ID   : rd_word = pinmux_pkg::CHIP_ID_VAL;
         pinmux_pkg::IDX_FUSE_ID   : rd_word = fuse_mhartid;
         pinmux_pkg::IDX_GPIO_IN   : rd_word = gpio_data_in;
         pinmux_pkg::IDX_GPIO_OUT  : rd_word = gpio_cfg.out_data;
         pinmux_pkg::IDX_GPIO_DIR  : rd_word = gpio_cfg.dir_sel;
         pinmux_pkg::IDX_GPIO_TYPE : rd_word = gpio_cfg.out_type;
         pinmux_pkg::IDX_INT_STAT  : rd_word = int_status;
         pinmux_pkg::IDX_INT_SET   : rd_word = int_status;   // Mirror of status
         pinmux_pkg::IDX_INT_MASK  : rd_word = int_mask;
         pinmux_pkg::IDX_POS_SEL   : rd_word = gpio_cfg.posedge_sel;
         pinmux_pkg::IDX_NEG_SEL   : rd_word = gpio_cfg.negedge_sel;
         pinmux_pkg::IDX_MFUNC_SEL : rd_word = gpio_cfg.multi_func_sel;
         default                   : rd_word = '0;
      endcase
   end

   // Read data captured with the ack, pre-write contents on a write
   always_ff @(posedge mclk)
   begin
      if (acc_req)
      begin
         reg_rdata <= rd_word;
      end
   end

endmodule

/* logic/pinmux_pkg.sv */
// Pin multiplexer register definitions

package pinmux_pkg;

   // ---------------------------------------------------------------------
   // Bus and pin widths
   // ---------------------------------------------------------------------
   localparam int DATA_W = 32;           // Register and bus word
   localparam int BE_W   = DATA_W / 8;   // One enable per byte
   localparam int ADDR_W = 8;            // Byte address
   localparam int IDX_W  = 5;            // Word index, addr[6:2]
   localparam int GPIO_W = 32;           // GPIO pin count

   typedef logic [DATA_W-1:0] reg_data_t;
   typedef logic [GPIO_W-1:0] gpio_vec_t;

   // Word indices of the register map
   typedef enum logic [IDX_W-1:0] {
      IDX_CHIP_ID   = 5'd0,   // Fixed identity
      IDX_FUSE_ID   = 5'd1,   // Core hart id
      IDX_GPIO_IN   = 5'd2,   // Captured pins, read only
      IDX_GPIO_OUT  = 5'd3,
      IDX_GPIO_DIR  = 5'd4,
      IDX_GPIO_TYPE = 5'd5,
      IDX_INT_STAT  = 5'd9,   // W1C
      IDX_INT_SET   = 5'd10,  // W1S, reads status
      IDX_INT_MASK  = 5'd11,
      IDX_POS_SEL   = 5'd12,
      IDX_NEG_SEL   = 5'd13,
      IDX_MFUNC_SEL = 5'd14
   } reg_idx_e;

   // ---------------------------------------------------------------------
   // Reset and constant values
   // ---------------------------------------------------------------------
   // Manufacturer 8949, chip 02, revision 01
   localparam reg_data_t CHIP_ID_VAL = 32'h8949_0201;
   localparam reg_data_t FUSE_ID_RST = 32'hA55A_A55A;

   // One write command from the bus decoder
   typedef struct packed {
      logic            en;      // Single cycle strobe
      reg_idx_e        idx;     // Target word
      logic [BE_W-1:0] be;      // Byte lanes
      reg_data_t       wdata;
   } reg_wr_t;

   // GPIO configuration words as seen by the pad logic
   typedef struct packed {
      gpio_vec_t out_data;        // Output level
      gpio_vec_t dir_sel;         // Pad direction
      gpio_vec_t out_type;        // Static or waveform
      gpio_vec_t posedge_sel;     // Rising edge irq enable
      gpio_vec_t negedge_sel;     // Falling edge irq enable
      gpio_vec_t multi_func_sel;  // Alternate function
   } gpio_cfg_t;

endpackage
